/* logic/frogger_pkg.sv */
// shared types and constants for the pixel colour pipeline
//   coordinate and colour channel types, pixel class enum
//   screen wrap limit, frog cell geometry and hit-box insets
//   solid colours for every pixel class
`default_nettype none

package frogger_pkg;

	// 11-bit screen coordinate, same width as the VGA counters
	typedef logic [10:0] coord_t;

	typedef logic [7:0] color8_t;

	typedef struct packed
	{
		color8_t r;
		color8_t g;
		color8_t b;
	} rgb_t;

	// what covers a pixel, objects first, then background bands
	typedef enum logic [3:0]
	{
		CLASS_FROG       = 4'd0,
		CLASS_CAR_RIGHT  = 4'd1,
		CLASS_CAR_LEFT   = 4'd2,
		CLASS_LPAD       = 4'd3,
		CLASS_WATER      = 4'd4,
		CLASS_DARK_GRASS = 4'd5,
		CLASS_GRASS      = 4'd6,
		CLASS_LANE_MARK  = 4'd7,
		CLASS_PAVEMENT   = 4'd8,
		CLASS_BLANK      = 4'd9
	} pixel_class_t;

	// ---------------------------------------------------------------------
	// geometry
	// ---------------------------------------------------------------------

	// x at or above this is partly off the left edge
	localparam coord_t WRAP_LIMIT = 11'd680;

	localparam coord_t FROG_W = 11'd40;
	localparam coord_t FROG_H = 11'd40;

	// hit box is smaller than the 40x40 cell
	localparam coord_t FROG_INSET_L = 11'd7;
	localparam coord_t FROG_INSET_R = 11'd7;
	localparam coord_t FROG_INSET_T = 11'd10;
	localparam coord_t FROG_INSET_B = 11'd5;

	// ---------------------------------------------------------------------
	// colours, red / green / blue
	// ---------------------------------------------------------------------
	localparam rgb_t COLOR_FROG       = '{r: 8'd0,   g: 8'd255, b: 8'd64};
	localparam rgb_t COLOR_CAR_RIGHT  = '{r: 8'd200, g: 8'd0,   b: 8'd0};
	localparam rgb_t COLOR_CAR_LEFT   = '{r: 8'd0,   g: 8'd0,   b: 8'd200};
	localparam rgb_t COLOR_LPAD       = '{r: 8'd0,   g: 8'd250, b: 8'd0};
	localparam rgb_t COLOR_WATER      = '{r: 8'd0,   g: 8'd200, b: 8'd255};
	localparam rgb_t COLOR_DARK_GRASS = '{r: 8'd0,   g: 8'd100, b: 8'd0};
	localparam rgb_t COLOR_GRASS      = '{r: 8'd0,   g: 8'd200, b: 8'd0};
	localparam rgb_t COLOR_LANE_MARK  = '{r: 8'd255, g: 8'd204, b: 8'd0};
	localparam rgb_t COLOR_PAVEMENT   = '{r: 8'd69,  g: 8'd69,  b: 8'd69};
	localparam rgb_t COLOR_BLANK      = '{r: 8'd255, g: 8'd255, b: 8'd255};

endpackage

`default_nettype wire

/* logic/sprite_row_hit.sv */
// hit test for one row of equal-sized objects
//   only slots below count are drawn
//   objects past the wrap limit cover columns from 0 onwards
`timescale 1ns/1ps
`default_nettype none

module sprite_row_hit #(
	parameter int OBJ_W   = 80,
	parameter int OBJ_H   = 40,
	parameter int MAX_OBJ = 4
) (
	input  wire frogger_pkg::coord_t               draw_x,
	input  wire frogger_pkg::coord_t               draw_y,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] obj_x,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] obj_y,
	input  wire logic [2:0]                        count,
	output logic                                   row_hit
);

	localparam frogger_pkg::coord_t OBJ_W_C = frogger_pkg::coord_t'(OBJ_W);
	localparam frogger_pkg::coord_t OBJ_H_C = frogger_pkg::coord_t'(OBJ_H);

	logic [MAX_OBJ-1:0] slot_hit;

	genvar i;
	generate
		for (i = 0; i < MAX_OBJ; i++)
		begin : g_slot
			frogger_pkg::coord_t x_lo;
			frogger_pkg::coord_t x_hi;
			frogger_pkg::coord_t y_hi;

			always_comb
			begin
				// right and bottom edges wrap modulo 2^11
				x_hi = obj_x[i] + OBJ_W_C;
				y_hi = obj_y[i] + OBJ_H_C;

				// partly off the left edge, span starts at column 0
				if (obj_x[i] < frogger_pkg::WRAP_LIMIT)
					x_lo = obj_x[i];
				else
					x_lo = '0;

				slot_hit[i] = (3'(i) < count) &&
					(draw_x >= x_lo) && (draw_x <= x_hi) &&
					(draw_y >= obj_y[i]) && (draw_y <= y_hi);
			end
		end
	endgenerate

	// any active slot in the row
	assign row_hit = |slot_hit;

endmodule

`default_nettype wire

/* logic/background_zone.sv */
// background band classifier
//   water, dark grass, grass, lane marks, pavement, blank
//   first matching band wins
`timescale 1ns/1ps
`default_nettype none

module background_zone (
	input  wire frogger_pkg::coord_t  draw_x,
	input  wire frogger_pkg::coord_t  draw_y,
	output frogger_pkg::pixel_class_t bg_class
);

	logic in_water;
	logic in_top_y;
	logic dark_x;
	logic gap_x;
	logic grass_y;
	logic lane_y;
	logic lane_x;
	logic in_road;

	// ---------------------------------------------------------------------
	// band conditions
	// ---------------------------------------------------------------------

	// river
	assign in_water = (draw_y >= 11'd80) && (draw_y <= 11'd239);

	// top strip with the home bays
	assign in_top_y = (draw_y >= 11'd40) && (draw_y <= 11'd79);

	assign dark_x = (draw_x <= 11'd119) ||
		((draw_x >= 11'd160) && (draw_x <= 11'd279)) ||
		((draw_x >= 11'd320) && (draw_x <= 11'd479)) ||
		((draw_x >= 11'd520) && (draw_x <= 11'd679));

	// lighter gaps between the dark grass blocks
	assign gap_x = ((draw_x >= 11'd120) && (draw_x <= 11'd159)) ||
		((draw_x >= 11'd280) && (draw_x <= 11'd319)) ||
		((draw_x >= 11'd480) && (draw_x <= 11'd519));

	// median strip and the bottom start area
	assign grass_y = ((draw_y >= 11'd240) && (draw_y <= 11'd279)) ||
		(draw_y >= 11'd440);

	// dashed markings between the four lanes
	assign lane_y = ((draw_y >= 11'd318) && (draw_y <= 11'd322)) ||
		((draw_y >= 11'd358) && (draw_y <= 11'd362)) ||
		((draw_y >= 11'd398) && (draw_y <= 11'd402));

	assign lane_x = (draw_x <= 11'd100) ||
		((draw_x >= 11'd200) && (draw_x <= 11'd300)) ||
		((draw_x >= 11'd400) && (draw_x <= 11'd500)) ||
		(draw_x >= 11'd600);

	assign in_road = (draw_y >= 11'd280) && (draw_y <= 11'd439);

	// ---------------------------------------------------------------------
	// band select
	// ---------------------------------------------------------------------
	always_comb
	begin
		if (in_water)
			bg_class = frogger_pkg::CLASS_WATER;
		else if (in_top_y && dark_x)
			bg_class = frogger_pkg::CLASS_DARK_GRASS;
		else if (grass_y || (in_top_y && gap_x))
			bg_class = frogger_pkg::CLASS_GRASS;
		else if (lane_y && lane_x)
			bg_class = frogger_pkg::CLASS_LANE_MARK;
		else if (in_road)
			bg_class = frogger_pkg::CLASS_PAVEMENT;
		else
			bg_class = frogger_pkg::CLASS_BLANK;
	end

endmodule

`default_nettype wire

/* logic/layer_priority.sv */
// layer priority and first pipeline stage
//   frog hit box with inset margins
//   frog, car rows 1 to 4, lily pads, then background
`timescale 1ns/1ps
`default_nettype none

module layer_priority (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire frogger_pkg::coord_t       draw_x,
	input  wire frogger_pkg::coord_t       draw_y,
	input  wire frogger_pkg::coord_t       frog_x,
	input  wire frogger_pkg::coord_t       frog_y,
	input  wire logic [3:0]                car_hit,
	input  wire logic [3:0]                lpad_hit,
	input  wire frogger_pkg::pixel_class_t bg_class,
	output frogger_pkg::pixel_class_t      pix_class
);

	frogger_pkg::coord_t frog_x_lo;
	frogger_pkg::coord_t frog_x_hi;
	frogger_pkg::coord_t frog_y_lo;
	frogger_pkg::coord_t frog_y_hi;
	logic frog_hit;
	frogger_pkg::pixel_class_t next_class;

	// ---------------------------------------------------------------------
	// frog hit box
	// ---------------------------------------------------------------------
	assign frog_x_lo = frog_x + frogger_pkg::FROG_INSET_L;
	assign frog_x_hi = frog_x + frogger_pkg::FROG_W - frogger_pkg::FROG_INSET_R;
	assign frog_y_lo = frog_y + frogger_pkg::FROG_INSET_T;
	assign frog_y_hi = frog_y + frogger_pkg::FROG_H - frogger_pkg::FROG_INSET_B;

	assign frog_hit = (draw_x >= frog_x_lo) && (draw_x <= frog_x_hi) &&
		(draw_y >= frog_y_lo) && (draw_y <= frog_y_hi);

	// ---------------------------------------------------------------------
	// priority select
	// ---------------------------------------------------------------------

	// odd rows drive right, even rows drive left
	always_comb
	begin
		if (frog_hit)
			next_class = frogger_pkg::CLASS_FROG;
		else if (car_hit[0])
			next_class = frogger_pkg::CLASS_CAR_RIGHT;
		else if (car_hit[1])
			next_class = frogger_pkg::CLASS_CAR_LEFT;
		else if (car_hit[2])
			next_class = frogger_pkg::CLASS_CAR_RIGHT;
		else if (car_hit[3])
			next_class = frogger_pkg::CLASS_CAR_LEFT;
		else if (|lpad_hit)
			next_class = frogger_pkg::CLASS_LPAD;
		else
			next_class = bg_class;
	end

	// stage one
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pix_class <= frogger_pkg::CLASS_BLANK;
		else
			pix_class <= next_class;
	end

endmodule

`default_nettype wire

/* logic/color_lookup.sv */
// class to colour lookup, second pipeline stage
//   solid colour per pixel class, registered rgb outputs
`timescale 1ns/1ps
`default_nettype none

module color_lookup (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire frogger_pkg::pixel_class_t pix_class,
	output frogger_pkg::color8_t           red,
	output frogger_pkg::color8_t           green,
	output frogger_pkg::color8_t           blue
);

	frogger_pkg::rgb_t rgb_sel;

	always_comb
	begin
		case (pix_class)
			frogger_pkg::CLASS_FROG:       rgb_sel = frogger_pkg::COLOR_FROG;
			frogger_pkg::CLASS_CAR_RIGHT:  rgb_sel = frogger_pkg::COLOR_CAR_RIGHT;
			frogger_pkg::CLASS_CAR_LEFT:   rgb_sel = frogger_pkg::COLOR_CAR_LEFT;
			frogger_pkg::CLASS_LPAD:       rgb_sel = frogger_pkg::COLOR_LPAD;
			frogger_pkg::CLASS_WATER:      rgb_sel = frogger_pkg::COLOR_WATER;
			frogger_pkg::CLASS_DARK_GRASS: rgb_sel = frogger_pkg::COLOR_DARK_GRASS;
			frogger_pkg::CLASS_GRASS:      rgb_sel = frogger_pkg::COLOR_GRASS;
			frogger_pkg::CLASS_LANE_MARK:  rgb_sel = frogger_pkg::COLOR_LANE_MARK;
			frogger_pkg::CLASS_PAVEMENT:   rgb_sel = frogger_pkg::COLOR_PAVEMENT;
			// unused codes show as blank
			default:                       rgb_sel = frogger_pkg::COLOR_BLANK;
		endcase
	end

	// ---------------------------------------------------------------------
	// stage two, outputs dark until the first pixel arrives
	// ---------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end
		else
		begin
			red   <= rgb_sel.r;
			green <= rgb_sel.g;
			blue  <= rgb_sel.b;
		end
	end

endmodule

`default_nettype wire

/* logic/frogger_color_mapper.sv */
// frogger pixel colour stage, top level
//   four car rows and four lily-pad rows of hit units
//   background bands, layer priority and colour lookup
//   two cycles from draw_x / draw_y to rgb
`timescale 1ns/1ps
`default_nettype none

module frogger_color_mapper #(
	parameter int MAX_OBJ = 4,
	parameter int CAR_W   = 80,
	parameter int CAR_H   = 40,
	parameter int LPAD_W  = 40,
	parameter int LPAD_H  = 40
) (
	input  wire                                    clk,
	input  wire                                    arst_n,
	input  wire frogger_pkg::coord_t               draw_x,
	input  wire frogger_pkg::coord_t               draw_y,
	input  wire frogger_pkg::coord_t               frog_x,
	input  wire frogger_pkg::coord_t               frog_y,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] car_row1_x,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] car_row1_y,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] car_row2_x,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] car_row2_y,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] car_row3_x,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] car_row3_y,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] car_row4_x,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] car_row4_y,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] lpad_row1_x,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] lpad_row1_y,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] lpad_row2_x,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] lpad_row2_y,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] lpad_row3_x,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] lpad_row3_y,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] lpad_row4_x,
	input  wire frogger_pkg::coord_t [MAX_OBJ-1:0] lpad_row4_y,
	input  wire logic [2:0]                        car_row1_count,
	input  wire logic [2:0]                        car_row2_count,
	input  wire logic [2:0]                        car_row3_count,
	input  wire logic [2:0]                        car_row4_count,
	input  wire logic [2:0]                        lpad_row1_count,
	input  wire logic [2:0]                        lpad_row2_count,
	input  wire logic [2:0]                        lpad_row3_count,
	input  wire logic [2:0]                        lpad_row4_count,
	output frogger_pkg::color8_t                   red,
	output frogger_pkg::color8_t                   green,
	output frogger_pkg::color8_t                   blue
);

	// bit 0 is row 1
	wire logic [3:0] car_hit;
	wire logic [3:0] lpad_hit;
	wire frogger_pkg::pixel_class_t bg_class;
	wire frogger_pkg::pixel_class_t pix_class;

	// ---------------------------------------------------------------------
	// car rows
	// ---------------------------------------------------------------------
	sprite_row_hit #(.OBJ_W(CAR_W), .OBJ_H(CAR_H), .MAX_OBJ(MAX_OBJ)) car_row1_i (
		.draw_x(draw_x), .draw_y(draw_y), .obj_x(car_row1_x), .obj_y(car_row1_y),
		.count(car_row1_count), .row_hit(car_hit[0])
	);
	sprite_row_hit #(.OBJ_W(CAR_W), .OBJ_H(CAR_H), .MAX_OBJ(MAX_OBJ)) car_row2_i (
		.draw_x(draw_x), .draw_y(draw_y), .obj_x(car_row2_x), .obj_y(car_row2_y),
		.count(car_row2_count), .row_hit(car_hit[1])
	);
	sprite_row_hit #(.OBJ_W(CAR_W), .OBJ_H(CAR_H), .MAX_OBJ(MAX_OBJ)) car_row3_i (
		.draw_x(draw_x), .draw_y(draw_y), .obj_x(car_row3_x), .obj_y(car_row3_y),
		.count(car_row3_count), .row_hit(car_hit[2])
	);
	sprite_row_hit #(.OBJ_W(CAR_W), .OBJ_H(CAR_H), .MAX_OBJ(MAX_OBJ)) car_row4_i (
		.draw_x(draw_x), .draw_y(draw_y), .obj_x(car_row4_x), .obj_y(car_row4_y),
		.count(car_row4_count), .row_hit(car_hit[3])
	);

	// ---------------------------------------------------------------------
	// lily-pad rows
	// ---------------------------------------------------------------------
	sprite_row_hit #(.OBJ_W(LPAD_W), .OBJ_H(LPAD_H), .MAX_OBJ(MAX_OBJ)) lpad_row1_i (
		.draw_x(draw_x), .draw_y(draw_y), .obj_x(lpad_row1_x), .obj_y(lpad_row1_y),
		.count(lpad_row1_count), .row_hit(lpad_hit[0])
	);
	sprite_row_hit #(.OBJ_W(LPAD_W), .OBJ_H(LPAD_H), .MAX_OBJ(MAX_OBJ)) lpad_row2_i (
		.draw_x(draw_x), .draw_y(draw_y), .obj_x(lpad_row2_x), .obj_y(lpad_row2_y),
		.count(lpad_row2_count), .row_hit(lpad_hit[1])
	);
	sprite_row_hit #(.OBJ_W(LPAD_W), .OBJ_H(LPAD_H), .MAX_OBJ(MAX_OBJ)) lpad_row3_i (
		.draw_x(draw_x), .draw_y(draw_y), .obj_x(lpad_row3_x), .obj_y(lpad_row3_y),
		.count(lpad_row3_count), .row_hit(lpad_hit[2])
	);
	sprite_row_hit #(.OBJ_W(LPAD_W), .OBJ_H(LPAD_H), .MAX_OBJ(MAX_OBJ)) lpad_row4_i (
		.draw_x(draw_x), .draw_y(draw_y), .obj_x(lpad_row4_x), .obj_y(lpad_row4_y),
		.count(lpad_row4_count), .row_hit(lpad_hit[3])
	);

	// ---------------------------------------------------------------------
	// background and pipeline
	// ---------------------------------------------------------------------
	background_zone background_zone_i (
		.draw_x   (draw_x),
		.draw_y   (draw_y),
		.bg_class (bg_class)
	);

	// stage one
	layer_priority layer_priority_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.draw_x    (draw_x),
		.draw_y    (draw_y),
		.frog_x    (frog_x),
		.frog_y    (frog_y),
		.car_hit   (car_hit),
		.lpad_hit  (lpad_hit),
		.bg_class  (bg_class),
		.pix_class (pix_class)
	);

	// stage two
	color_lookup color_lookup_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.pix_class (pix_class),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

endmodule

`default_nettype wire

/* verif/tb_pixel_model.svh */
// reference model of the pixel colour stage
//   background bands, frog hit box, object rows, layer priority
`ifndef TB_PIXEL_MODEL_SVH
`define TB_PIXEL_MODEL_SVH

// expected colours, red in the top byte
localparam logic [23:0] RGB_FROG       = 24'h00ff40;
localparam logic [23:0] RGB_CAR_RIGHT  = 24'hc80000;
localparam logic [23:0] RGB_CAR_LEFT   = 24'h0000c8;
localparam logic [23:0] RGB_LPAD       = 24'h00fa00;
localparam logic [23:0] RGB_WATER      = 24'h00c8ff;
localparam logic [23:0] RGB_DARK_GRASS = 24'h006400;
localparam logic [23:0] RGB_GRASS      = 24'h00c800;
localparam logic [23:0] RGB_LANE_MARK  = 24'hffcc00;
localparam logic [23:0] RGB_PAVEMENT   = 24'h454545;
localparam logic [23:0] RGB_BLANK      = 24'hffffff;

function automatic bit in_range(input int v, input int lo, input int hi);
	return (v >= lo) && (v <= hi);
endfunction

// bands in order, first match wins
function automatic logic [23:0] band_rgb(input int x, input int y);
	if (in_range(y, 80, 239))
		return RGB_WATER;
	if (in_range(y, 40, 79) && (x <= 119 || in_range(x, 160, 279) ||
		in_range(x, 320, 479) || in_range(x, 520, 679)))
		return RGB_DARK_GRASS;
	if (in_range(y, 240, 279) || y >= 440 || (in_range(y, 40, 79) &&
		(in_range(x, 120, 159) || in_range(x, 280, 319) || in_range(x, 480, 519))))
		return RGB_GRASS;
	if ((in_range(y, 318, 322) || in_range(y, 358, 362) || in_range(y, 398, 402)) &&
		(x <= 100 || in_range(x, 200, 300) || in_range(x, 400, 500) || x >= 600))
		return RGB_LANE_MARK;
	if (in_range(y, 280, 439))
		return RGB_PAVEMENT;
	return RGB_BLANK;
endfunction

// inset box inside the 40x40 frog cell
function automatic bit frog_covers(input int x, input int y, input int fx, input int fy);
	return in_range(x, fx + 7, fx + 33) && in_range(y, fy + 10, fy + 35);
endfunction

// four slots of 11-bit coordinates, slot 0 in the low bits
function automatic bit row_covers(input int x, input int y, input logic [43:0] xs,
	input logic [43:0] ys, input int cnt, input int w, input int h);
	int ox;
	int oy;
	int lo;
	int s;
	bit hit;
	hit = 1'b0;
	for (s = 0; s < 4; s++)
	begin
		ox = xs[s*11 +: 11];
		oy = ys[s*11 +: 11];
		// past the wrap limit the span starts at column 0
		lo = (ox >= 680) ? 0 : ox;
		if (s < cnt && in_range(x, lo, (ox + w) % 2048) && in_range(y, oy, (oy + h) % 2048))
			hit = 1'b1;
	end
	return hit;
endfunction

function automatic logic [23:0] pixel_rgb(input int x, input int y, input int fx,
	input int fy, input logic [3:0] car_h, input logic [3:0] pad_h);
	if (frog_covers(x, y, fx, fy))
		return RGB_FROG;
	if (car_h[0])
		return RGB_CAR_RIGHT;
	if (car_h[1])
		return RGB_CAR_LEFT;
	if (car_h[2])
		return RGB_CAR_RIGHT;
	if (car_h[3])
		return RGB_CAR_LEFT;
	if (|pad_h)
		return RGB_LPAD;
	return band_rgb(x, y);
endfunction

`endif

/* verif/tb_frogger_color_mapper.sv */
// testbench for the frogger pixel colour stage
//   directed band, frog, car row, wrap and priority tests
//   random back-to-back pixel stream checked through a queue
`timescale 1ns/1ps
`default_nettype none

module tb_frogger_color_mapper;

	// tests take roughly 700 cycles
	localparam int MAX_CYCLES = 4000;
	localparam int STREAM_LEN = 300;

	logic clk;
	logic arst_n;
	frogger_pkg::coord_t draw_x;
	frogger_pkg::coord_t draw_y;
	frogger_pkg::coord_t frog_x;
	frogger_pkg::coord_t frog_y;
	// index 0 is row 1
	frogger_pkg::coord_t [3:0] car_x [4];
	frogger_pkg::coord_t [3:0] car_y [4];
	frogger_pkg::coord_t [3:0] pad_x [4];
	frogger_pkg::coord_t [3:0] pad_y [4];
	logic [2:0] car_cnt [4];
	logic [2:0] pad_cnt [4];
	frogger_pkg::color8_t red;
	frogger_pkg::color8_t green;
	frogger_pkg::color8_t blue;
	int seed = 32'h3e07_5898;
	int cycle_count;
	logic [23:0] expect_q [$];

	`include "tb_pixel_model.svh"

	frogger_color_mapper #(
		.MAX_OBJ(4), .CAR_W(80), .CAR_H(40), .LPAD_W(40), .LPAD_H(40)
	) frogger_color_mapper_i (
		.clk(clk), .arst_n(arst_n), .draw_x(draw_x), .draw_y(draw_y),
		.frog_x(frog_x), .frog_y(frog_y),
		.car_row1_x(car_x[0]), .car_row1_y(car_y[0]), .car_row2_x(car_x[1]),
		.car_row2_y(car_y[1]), .car_row3_x(car_x[2]), .car_row3_y(car_y[2]),
		.car_row4_x(car_x[3]), .car_row4_y(car_y[3]),
		.lpad_row1_x(pad_x[0]), .lpad_row1_y(pad_y[0]), .lpad_row2_x(pad_x[1]),
		.lpad_row2_y(pad_y[1]), .lpad_row3_x(pad_x[2]), .lpad_row3_y(pad_y[2]),
		.lpad_row4_x(pad_x[3]), .lpad_row4_y(pad_y[3]),
		.car_row1_count(car_cnt[0]), .car_row2_count(car_cnt[1]),
		.car_row3_count(car_cnt[2]), .car_row4_count(car_cnt[3]),
		.lpad_row1_count(pad_cnt[0]), .lpad_row2_count(pad_cnt[1]),
		.lpad_row3_count(pad_cnt[2]), .lpad_row4_count(pad_cnt[3]),
		.red(red), .green(green), .blue(blue)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic int random_below(input int span);
		return {$random(seed)} % span;
	endfunction

	function automatic logic [23:0] expected_pixel(input int x, input int y);
		logic [3:0] car_h;
		logic [3:0] pad_h;
		int r;
		for (r = 0; r < 4; r++)
		begin
			car_h[r] = row_covers(x, y, car_x[r], car_y[r], car_cnt[r], 80, 40);
			pad_h[r] = row_covers(x, y, pad_x[r], pad_y[r], pad_cnt[r], 40, 40);
		end
		return pixel_rgb(x, y, frog_x, frog_y, car_h, pad_h);
	endfunction

	task check_value(input string what, input logic [7:0] got, input logic [7:0] expected);
		if (got !== expected)
		begin
			$display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
			$display("TEST FAILED");
			$fatal(1, "colour mismatch");
		end
	endtask

	task compare_rgb(input logic [23:0] exp_rgb, input string where);
		check_value({where, " red"}, red, exp_rgb[23:16]);
		check_value({where, " green"}, green, exp_rgb[15:8]);
		check_value({where, " blue"}, blue, exp_rgb[7:0]);
	endtask

	// one pixel through both stages and sampled on the falling edge
	task verify_pixel(input int x, input int y);
		@(posedge clk);
		draw_x <= x;
		draw_y <= y;
		repeat (2) @(posedge clk);
		@(negedge clk);
		compare_rgb(expected_pixel(x, y), $sformatf("pixel (%0d,%0d)", x, y));
	endtask

	task reset_dut;
		@(posedge clk);
		arst_n <= 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		compare_rgb(24'h000000, "after reset");
	endtask

	// no objects and the frog parked below the screen
	task clear_objects;
		int r;
		@(posedge clk);
		frog_x <= '0;
		frog_y <= 11'd1000;
		for (r = 0; r < 4; r++)
		begin
			car_cnt[r] <= '0;
			pad_cnt[r] <= '0;
			car_x[r] <= '0;
			car_y[r] <= '0;
			pad_x[r] <= '0;
			pad_y[r] <= '0;
		end
	endtask

	task place_frog(input int x, input int y);
		@(posedge clk);
		frog_x <= x;
		frog_y <= y;
	endtask

	task place_object(input bit pad, input int row, input int slot, input int x, input int y,
		input int count);
		@(posedge clk);
		if (pad)
		begin
			pad_x[row-1][slot] <= x;
			pad_y[row-1][slot] <= y;
			pad_cnt[row-1] <= count;
		end
		else
		begin
			car_x[row-1][slot] <= x;
			car_y[row-1][slot] <= y;
			car_cnt[row-1] <= count;
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task background_bands;
		int px[36];
		int py[36];
		int i;
		px = '{0, 100, 0, 119, 120, 159, 160, 279, 280, 319, 320, 479, 480, 519, 520, 679,
			680, 0, 700, 0, 639, 0, 150, 0, 100, 101, 199, 200, 300, 400, 500, 600,
			639, 0, 0, 639};
		py = '{0, 39, 40, 40, 40, 79, 79, 60, 60, 60, 60, 60, 60, 60, 60, 60,
			60, 80, 239, 240, 279, 280, 317, 318, 322, 320, 360, 358, 362, 398, 402, 400,
			403, 439, 440, 479};
		clear_objects();
		for (i = 0; i < 36; i++)
			verify_pixel(px[i], py[i]);
	endtask

	task frog_hit_box;
		clear_objects();
		place_frog(200, 300);
		verify_pixel(207, 310);
		verify_pixel(233, 335);
		verify_pixel(207, 335);
		verify_pixel(233, 310);
		verify_pixel(206, 320);
		verify_pixel(234, 320);
		verify_pixel(220, 309);
		verify_pixel(220, 336);
	endtask

	task car_row_order;
		clear_objects();
		// slot 2 of row 1 sits above the count
		place_object(0, 1, 0, 100, 280, 2);
		place_object(0, 1, 1, 300, 280, 2);
		place_object(0, 1, 2, 500, 280, 2);
		place_object(0, 2, 0, 120, 290, 1);
		place_object(0, 3, 0, 400, 360, 4);
		place_object(0, 4, 0, 440, 370, 4);
		verify_pixel(140, 300);
		verify_pixel(180, 320);
		verify_pixel(340, 300);
		verify_pixel(540, 300);
		verify_pixel(190, 300);
		verify_pixel(200, 330);
		verify_pixel(201, 300);
		verify_pixel(420, 365);
		verify_pixel(480, 400);
		verify_pixel(500, 380);
		verify_pixel(520, 410);
		verify_pixel(521, 410);
	endtask

	task left_edge_wrap;
		clear_objects();
		place_object(0, 2, 0, 2000, 300, 1);
		place_object(1, 1, 0, 2030, 100, 1);
		place_object(0, 3, 0, 680, 400, 1);
		place_object(0, 4, 0, 679, 450, 1);
		verify_pixel(0, 310);
		verify_pixel(32, 310);
		verify_pixel(33, 310);
		verify_pixel(0, 120);
		verify_pixel(22, 140);
		verify_pixel(23, 120);
		verify_pixel(22, 141);
		verify_pixel(0, 420);
		verify_pixel(639, 440);
		verify_pixel(678, 460);
		verify_pixel(679, 460);
		verify_pixel(759, 460);
	endtask

	task layer_order;
		clear_objects();
		place_frog(100, 100);
		place_object(0, 4, 0, 90, 100, 1);
		place_object(1, 3, 0, 80, 100, 1);
		place_object(1, 4, 0, 300, 100, 1);
		verify_pixel(110, 120);
		verify_pixel(133, 135);
		verify_pixel(105, 120);
		verify_pixel(170, 120);
		verify_pixel(171, 120);
		verify_pixel(85, 120);
		verify_pixel(300, 100);
		verify_pixel(340, 140);
		verify_pixel(341, 140);
	endtask

	// new pixel every cycle and each output checked two edges after its drive
	task random_stream;
		int i;
		int r;
		int s;
		logic [23:0] exp_rgb;
		reset_dut();
		for (i = 0; i < STREAM_LEN + 2; i++)
		begin
			@(posedge clk);
			if (i < STREAM_LEN)
			begin
				draw_x <= random_below(800);
				draw_y <= random_below(525);
				frog_x <= random_below(680);
				frog_y <= random_below(480);
				for (r = 0; r < 4; r++)
				begin
					car_cnt[r] <= random_below(8);
					pad_cnt[r] <= random_below(8);
					for (s = 0; s < 4; s++)
					begin
						car_x[r][s] <= random_below(2048);
						car_y[r][s] <= random_below(480);
						pad_x[r][s] <= random_below(2048);
						pad_y[r][s] <= random_below(480);
					end
				end
			end
			@(negedge clk);
			if (i < STREAM_LEN)
				expect_q.push_back(expected_pixel(draw_x, draw_y));
			if (i >= 2)
			begin
				exp_rgb = expect_q.pop_front();
				compare_rgb(exp_rgb, $sformatf("stream pixel %0d", i - 2));
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial
	begin
		int r;
		arst_n = 1'b0;
		draw_x = '0;
		draw_y = '0;
		frog_x = '0;
		frog_y = 11'd1000;
		for (r = 0; r < 4; r++)
		begin
			car_x[r] = '0;
			car_y[r] = '0;
			pad_x[r] = '0;
			pad_y[r] = '0;
			car_cnt[r] = '0;
			pad_cnt[r] = '0;
		end
		reset_dut();
		background_bands();
		frog_hit_box();
		car_row_order();
		left_edge_wrap();
		layer_order();
		random_stream();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verif
logic/frogger_pkg.sv
logic/sprite_row_hit.sv
logic/background_zone.sv
logic/layer_priority.sv
logic/color_lookup.sv
logic/frogger_color_mapper.sv
verif/tb_frogger_color_mapper.sv
